// File: common/switch_pkg.sv
package switch_pkg;

    // header geometry
    localparam int HDR_LEN = 8;

    typedef logic [7:0] byte_t;

    // byte 0 sits in the low bits
    typedef byte_t [HDR_LEN-1:0] hdr_t;

    typedef logic [$clog2(HDR_LEN)-1:0] off_t;

    // per-stage lookup table
    localparam int TBL_ENTRIES = 4;

    typedef logic [$clog2(TBL_ENTRIES)-1:0] tbl_idx_t;

    // stage select on the config bus
    localparam int NUM_STAGES = 2;

    typedef logic [$clog2(NUM_STAGES)-1:0] stage_id_t;

endpackage

// File: common/tbl_cfg_if.sv
`timescale 1ns/1ns

interface tbl_cfg_if import switch_pkg::*; ();

    logic      cfg_wr;
    stage_id_t cfg_stage;
    tbl_idx_t  cfg_idx;
    byte_t     cfg_key;
    byte_t     cfg_val;

    modport master (
        output cfg_wr, cfg_stage, cfg_idx, cfg_key, cfg_val
    );

    // every stage sees every write
    modport slave (
        input cfg_wr, cfg_stage, cfg_idx, cfg_key, cfg_val
    );

endinterface

// File: hdl/hdr_buffer.sv
`timescale 1ns/1ns

module hdr_buffer import switch_pkg::*; #(
    parameter int DEPTH = 2
) (
    input  logic clk,
    input  logic rst_i,
    input  logic push_valid_i,
    input  hdr_t push_hdr_i,
    output logic push_credit_o,
    output logic head_valid_o,
    output hdr_t head_hdr_o,
    input  logic pop_i
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    hdr_t             mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             credit_q;
    logic             push_en;
    logic             pop_en;

    assign head_valid_o  = (count_q != '0);
    assign head_hdr_o    = mem_q[rd_ptr_q];
    assign push_credit_o = credit_q;

    assign push_en = push_valid_i && (count_q != CNT_W'(DEPTH));
    assign pop_en  = pop_i && head_valid_o;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_q <= 1'b0;
        end else begin
            if (push_en) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_en) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push_en, pop_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            // one slot freed, hand the credit back
            credit_q <= pop_en;
        end
    end

    always_ff @(posedge clk) begin
        if (push_en) begin
            mem_q[wr_ptr_q] <= push_hdr_i;
        end
    end

endmodule

// File: match_action_stage/match_table.sv
`timescale 1ns/1ns

module match_table import switch_pkg::*; #(
    parameter stage_id_t STAGE_ID = '0
) (
    input  logic     clk,
    input  logic     rst_i,
    tbl_cfg_if.slave cfg,
    input  byte_t    key_i,
    output logic     hit_o,
    output byte_t    val_o
);

    logic [TBL_ENTRIES-1:0] ent_vld_q;
    byte_t                  ent_key_q [TBL_ENTRIES];
    byte_t                  ent_val_q [TBL_ENTRIES];
    logic                   wr_en;

    // writes for the other stage are ignored
    assign wr_en = cfg.cfg_wr && (cfg.cfg_stage == STAGE_ID);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ent_vld_q <= '0;
        end else if (wr_en) begin
            ent_vld_q[cfg.cfg_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            ent_key_q[cfg.cfg_idx] <= cfg.cfg_key;
            ent_val_q[cfg.cfg_idx] <= cfg.cfg_val;
        end
    end

    // scan downwards so the lowest matching index wins
    always_comb begin
        hit_o = 1'b0;
        val_o = '0;
        for (int i = TBL_ENTRIES - 1; i >= 0; i--) begin
            if (ent_vld_q[i] && (ent_key_q[i] == key_i)) begin
                hit_o = 1'b1;
                val_o = ent_val_q[i];
            end
        end
    end

endmodule

// File: match_action_stage/match_action_stage.sv
`timescale 1ns/1ns

module match_action_stage import switch_pkg::*; #(
    parameter stage_id_t STAGE_ID = '0,
    parameter off_t      KEY_OFF  = '0,
    parameter off_t      SET_OFF  = '0,
    parameter byte_t     MISS_VAL = '0,
    parameter int        CREDITS  = 2
) (
    input  logic       clk,
    input  logic       rst_i,
    tbl_cfg_if.slave   cfg,
    // from the buffer in front
    input  logic       head_valid_i,
    input  hdr_t       head_hdr_i,
    output logic       pop_o,
    // to the next receiver
    output logic       out_valid_o,
    output hdr_t       out_hdr_o,
    input  logic       out_credit_i
);

    localparam int CRD_W = $clog2(CREDITS + 1);

    logic [CRD_W-1:0] credit_cnt_q;
    logic             tbl_hit;
    byte_t            tbl_val;
    hdr_t             next_hdr;
    logic             out_valid_q;
    hdr_t             out_hdr_q;

    match_table #(.STAGE_ID(STAGE_ID)) table_i (
        .clk(clk),
        .rst_i(rst_i),
        .cfg(cfg),
        .key_i(head_hdr_i[KEY_OFF]),
        .hit_o(tbl_hit),
        .val_o(tbl_val)
    );

    // only take a head when the receiver has room
    assign pop_o = head_valid_i && (credit_cnt_q != '0);

    always_comb begin
        next_hdr          = head_hdr_i;
        next_hdr[SET_OFF] = tbl_hit ? tbl_val : MISS_VAL;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            credit_cnt_q <= CRD_W'(CREDITS);
            out_valid_q  <= 1'b0;
        end else begin
            case ({pop_o, out_credit_i})
                2'b10:   credit_cnt_q <= credit_cnt_q - 1'b1;
                2'b01:   credit_cnt_q <= credit_cnt_q + 1'b1;
                default: credit_cnt_q <= credit_cnt_q;
            endcase
            out_valid_q <= pop_o;
        end
    end

    always_ff @(posedge clk) begin
        if (pop_o) begin
            out_hdr_q <= next_hdr;
        end
    end

    assign out_valid_o = out_valid_q;
    assign out_hdr_o   = out_hdr_q;

endmodule

// File: hdl/switch_pipeline.sv
`timescale 1ns/1ns

module switch_pipeline import switch_pkg::*; #(
    parameter int    BUF_DEPTH   = 2,
    parameter int    OUT_CREDITS = 2,
    parameter off_t  S0_KEY_OFF  = 3'd0,
    parameter off_t  S0_SET_OFF  = 3'd4,
    parameter byte_t S0_MISS_VAL = 8'hee,
    parameter off_t  S1_KEY_OFF  = 3'd4,
    parameter off_t  S1_SET_OFF  = 3'd5,
    parameter byte_t S1_MISS_VAL = 8'hdd
) (
    input  logic      clk,
    input  logic      rst_i,
    // header input
    input  logic      in_valid_i,
    input  hdr_t      in_hdr_i,
    output logic      in_credit_o,
    // header output
    output logic      out_valid_o,
    output hdr_t      out_hdr_o,
    input  logic      out_credit_i,
    // table configuration
    input  logic      cfg_wr_i,
    input  stage_id_t cfg_stage_i,
    input  tbl_idx_t  cfg_idx_i,
    input  byte_t     cfg_key_i,
    input  byte_t     cfg_val_i
);

    tbl_cfg_if cfg_bus ();

    assign cfg_bus.cfg_wr    = cfg_wr_i;
    assign cfg_bus.cfg_stage = cfg_stage_i;
    assign cfg_bus.cfg_idx   = cfg_idx_i;
    assign cfg_bus.cfg_key   = cfg_key_i;
    assign cfg_bus.cfg_val   = cfg_val_i;

    logic buf0_head_valid;
    hdr_t buf0_head_hdr;
    logic s0_pop;
    logic s0_out_valid;
    hdr_t s0_out_hdr;
    logic buf1_credit;
    logic buf1_head_valid;
    hdr_t buf1_head_hdr;
    logic s1_pop;

    // input -> buffer 0 -> stage 0
    hdr_buffer #(.DEPTH(BUF_DEPTH)) buf0_i (
        .clk(clk), .rst_i(rst_i),
        .push_valid_i(in_valid_i), .push_hdr_i(in_hdr_i), .push_credit_o(in_credit_o),
        .head_valid_o(buf0_head_valid), .head_hdr_o(buf0_head_hdr), .pop_i(s0_pop)
    );

    match_action_stage #(
        .STAGE_ID(stage_id_t'(0)), .KEY_OFF(S0_KEY_OFF), .SET_OFF(S0_SET_OFF),
        .MISS_VAL(S0_MISS_VAL), .CREDITS(BUF_DEPTH)
    ) stage0_i (
        .clk(clk), .rst_i(rst_i), .cfg(cfg_bus.slave),
        .head_valid_i(buf0_head_valid), .head_hdr_i(buf0_head_hdr), .pop_o(s0_pop),
        .out_valid_o(s0_out_valid), .out_hdr_o(s0_out_hdr), .out_credit_i(buf1_credit)
    );

    // stage 0 -> buffer 1 -> stage 1 -> output
    hdr_buffer #(.DEPTH(BUF_DEPTH)) buf1_i (
        .clk(clk), .rst_i(rst_i),
        .push_valid_i(s0_out_valid), .push_hdr_i(s0_out_hdr), .push_credit_o(buf1_credit),
        .head_valid_o(buf1_head_valid), .head_hdr_o(buf1_head_hdr), .pop_i(s1_pop)
    );

    match_action_stage #(
        .STAGE_ID(stage_id_t'(1)), .KEY_OFF(S1_KEY_OFF), .SET_OFF(S1_SET_OFF),
        .MISS_VAL(S1_MISS_VAL), .CREDITS(OUT_CREDITS)
    ) stage1_i (
        .clk(clk), .rst_i(rst_i), .cfg(cfg_bus.slave),
        .head_valid_i(buf1_head_valid), .head_hdr_i(buf1_head_hdr), .pop_o(s1_pop),
        .out_valid_o(out_valid_o), .out_hdr_o(out_hdr_o), .out_credit_i(out_credit_i)
    );

endmodule

// File: testbench/hdr_buffer_checker.sv
`timescale 1ns/1ns

module hdr_buffer_checker #(
    parameter int DEPTH = 2
) (
    input logic                       clk_i,
    input logic                       rst_i,
    input logic                       push_valid_i,
    input logic                       pop_i,
    input logic [$clog2(DEPTH+1)-1:0] count_i
);

    localparam int CNT_W = $clog2(DEPTH + 1);

    // a sender with no credit left must not push
    no_overflow: assert property (
        @(posedge clk_i) disable iff (rst_i)
        !(push_valid_i && count_i == CNT_W'(DEPTH))
    ) else $error("header pushed while the buffer was full");

    no_underflow: assert property (
        @(posedge clk_i) disable iff (rst_i)
        !(pop_i && count_i == '0)
    ) else $error("header popped while the buffer was empty");

endmodule

bind hdr_buffer hdr_buffer_checker #(.DEPTH(DEPTH)) buffer_chk_i (
    .clk_i(clk), .rst_i(rst_i), .push_valid_i(push_valid_i),
    .pop_i(pop_i), .count_i(count_q)
);

// File: testbench/tb_switch_pipeline.sv
`timescale 1ns/1ns

module tb_switch_pipeline import switch_pkg::*; ();

    localparam int    BUF_DEPTH   = 2;
    localparam int    OUT_CREDITS = 2;
    localparam off_t  S0_KEY      = 3'd0;
    localparam off_t  S0_SET      = 3'd4;
    localparam byte_t S0_MISS     = 8'hee;
    localparam off_t  S1_KEY      = 3'd4;
    localparam off_t  S1_SET      = 3'd5;
    localparam byte_t S1_MISS     = 8'hdd;
    localparam int    N_ROWS      = 12;
    localparam int    N_HOLD      = 8;
    localparam int    N_RAND      = 40;

    // one row is a table write or a header with its hand-computed result
    typedef struct packed {
        logic      is_cfg;
        stage_id_t stage;
        tbl_idx_t  idx;
        byte_t     key;
        byte_t     val;
        hdr_t      hdr;
        hdr_t      exp;
    } row_t;

    logic      clk = 1'b0;
    logic      rst_i;
    logic      in_valid_i;
    hdr_t      in_hdr_i;
    logic      in_credit_o;
    logic      out_valid_o;
    hdr_t      out_hdr_o;
    logic      out_credit_i;
    logic      cfg_wr_i;
    stage_id_t cfg_stage_i;
    tbl_idx_t  cfg_idx_i;
    byte_t     cfg_key_i;
    byte_t     cfg_val_i;

    row_t  rows [N_ROWS];
    logic  mdl_vld [NUM_STAGES][TBL_ENTRIES];
    byte_t mdl_key [NUM_STAGES][TBL_ENTRIES];
    byte_t mdl_val [NUM_STAGES][TBL_ENTRIES];
    hdr_t  send_q [$];
    hdr_t  exp_q [$];
    string name_q [$];
    int    seed = 32'h3b7d_7876;
    int    in_credits = 0;
    int    in_crd_seen = 0;
    int    out_seen = 0;
    int    owed_credits = 0;
    int    sent_cnt = 0;
    int    cycles = 0;
    int    cycle_limit = 200;
    logic  hold_credit = 1'b0;

    switch_pipeline #(
        .BUF_DEPTH(BUF_DEPTH), .OUT_CREDITS(OUT_CREDITS),
        .S0_KEY_OFF(S0_KEY), .S0_SET_OFF(S0_SET), .S0_MISS_VAL(S0_MISS),
        .S1_KEY_OFF(S1_KEY), .S1_SET_OFF(S1_SET), .S1_MISS_VAL(S1_MISS)
    ) dut_i (
        .clk(clk), .rst_i(rst_i),
        .in_valid_i(in_valid_i), .in_hdr_i(in_hdr_i), .in_credit_o(in_credit_o),
        .out_valid_o(out_valid_o), .out_hdr_o(out_hdr_o), .out_credit_i(out_credit_i),
        .cfg_wr_i(cfg_wr_i), .cfg_stage_i(cfg_stage_i), .cfg_idx_i(cfg_idx_i),
        .cfg_key_i(cfg_key_i), .cfg_val_i(cfg_val_i)
    );

    always #10 clk = ~clk;

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "run stopped at the first error");
    endtask

    function automatic byte_t lookup_entry(stage_id_t stage, byte_t key, byte_t miss);
        for (int i = 0; i < TBL_ENTRIES; i++) begin
            if (mdl_vld[stage][i] && mdl_key[stage][i] == key) begin
                return mdl_val[stage][i];
            end
        end
        return miss;
    endfunction

    // stage 1 keys on what stage 0 wrote
    function automatic hdr_t predict_header(hdr_t h);
        hdr_t r;
        r = h;
        r[S0_SET] = lookup_entry(1'b0, r[S0_KEY], S0_MISS);
        r[S1_SET] = lookup_entry(1'b1, r[S1_KEY], S1_MISS);
        return r;
    endfunction

    task automatic queue_header(hdr_t h, hdr_t e, string name);
        send_q.push_back(h);
        exp_q.push_back(e);
        name_q.push_back(name);
    endtask

    // everything is sampled and driven on the falling edge
    task automatic run_cycle();
        hdr_t  exp_hdr;
        string exp_name;
        @(negedge clk);
        cycles++;
        if (cycles > cycle_limit) begin
            abort_run($sformatf("no progress within %0d cycles, %0d headers still expected",
                                cycle_limit, exp_q.size()));
        end
        if (sent_cnt == 0) begin
            assert (!out_valid_o && !in_credit_o)
                else abort_run("output valid or input credit went high before any header was sent");
        end
        if (in_credit_o) begin
            in_credits++;
            in_crd_seen++;
        end
        assert (in_credits <= BUF_DEPTH)
            else abort_run("input buffer returned more credits than it has slots");
        if (out_valid_o) begin
            assert (exp_q.size() != 0)
                else abort_run("a header left the pipeline with none expected");
            exp_hdr  = exp_q.pop_front();
            exp_name = name_q.pop_front();
            assert (out_hdr_o === exp_hdr)
                else abort_run($sformatf("mismatch %s expected %h actual %h",
                                         exp_name, exp_hdr, out_hdr_o));
            out_seen++;
            owed_credits++;
        end
        if (!hold_credit && owed_credits > 0) begin
            out_credit_i = 1'b1;
            owed_credits--;
        end else begin
            out_credit_i = 1'b0;
        end
        if (send_q.size() != 0 && in_credits > 0) begin
            in_valid_i = 1'b1;
            in_hdr_i   = send_q.pop_front();
            in_credits--;
            sent_cnt++;
        end else begin
            in_valid_i = 1'b0;
        end
    endtask

    task automatic drain_pipeline();
        while (send_q.size() != 0 || exp_q.size() != 0 || owed_credits != 0) begin
            run_cycle();
        end
    endtask

    task automatic write_entry(stage_id_t stage, tbl_idx_t idx, byte_t key, byte_t val);
        cfg_wr_i    = 1'b1;
        cfg_stage_i = stage;
        cfg_idx_i   = idx;
        cfg_key_i   = key;
        cfg_val_i   = val;
        run_cycle();
        cfg_wr_i = 1'b0;
        mdl_vld[stage][idx] = 1'b1;
        mdl_key[stage][idx] = key;
        mdl_val[stage][idx] = val;
    endtask

    initial begin
        int          hdr_rows;
        int          out_mark;
        int          crd_mark;
        hdr_t        h;
        logic [31:0] rnd;
        rst_i        = 1'b1;
        in_valid_i   = 1'b0;
        in_hdr_i     = '0;
        out_credit_i = 1'b0;
        cfg_wr_i     = 1'b0;
        cfg_stage_i  = '0;
        cfg_idx_i    = '0;
        cfg_key_i    = '0;
        cfg_val_i    = '0;
        for (int s = 0; s < NUM_STAGES; s++) begin
            for (int i = 0; i < TBL_ENTRIES; i++) begin
                mdl_vld[s][i] = 1'b0;
                mdl_key[s][i] = '0;
                mdl_val[s][i] = '0;
            end
        end
        // is_cfg, stage, idx, key, val, header in, header expected
        rows[0]  = '{1'b0, 1'b0, 2'd0, 8'h00, 8'h00, 64'h0706050403020100, 64'h0706ddee03020100};
        rows[1]  = '{1'b0, 1'b0, 2'd0, 8'h00, 8'h00, 64'h1122334455667788, 64'h1122ddee55667788};
        rows[2]  = '{1'b1, 1'b0, 2'd0, 8'h00, 8'h10, 64'h0, 64'h0};
        rows[3]  = '{1'b1, 1'b1, 2'd0, 8'h10, 8'h20, 64'h0, 64'h0};
        rows[4]  = '{1'b1, 1'b1, 2'd1, 8'h88, 8'h99, 64'h0, 64'h0};
        rows[5]  = '{1'b0, 1'b0, 2'd0, 8'h00, 8'h00, 64'h0706050403020100, 64'h0706201003020100};
        rows[6]  = '{1'b0, 1'b0, 2'd0, 8'h00, 8'h00, 64'h1122334455667788, 64'h1122ddee55667788};
        rows[7]  = '{1'b1, 1'b0, 2'd0, 8'h00, 8'h30, 64'h0, 64'h0};
        rows[8]  = '{1'b1, 1'b0, 2'd2, 8'h00, 8'h40, 64'h0, 64'h0};
        rows[9]  = '{1'b0, 1'b0, 2'd0, 8'h00, 8'h00, 64'h0706050403020100, 64'h0706dd3003020100};
        rows[10] = '{1'b1, 1'b1, 2'd2, 8'h30, 8'h5a, 64'h0, 64'h0};
        rows[11] = '{1'b0, 1'b0, 2'd0, 8'h00, 8'h00, 64'hffffffffffffff00, 64'hffff5a30ffffff00};
        hdr_rows = 0;
        for (int r = 0; r < N_ROWS; r++) begin
            if (!rows[r].is_cfg) begin
                hdr_rows++;
            end
        end
        cycle_limit = 40 * (hdr_rows + N_HOLD + N_RAND) + 200;

        repeat (4) @(negedge clk);
        rst_i      = 1'b0;
        in_credits = BUF_DEPTH;
        repeat (5) run_cycle();

        // lookups must not race a table write
        for (int r = 0; r < N_ROWS; r++) begin
            if (rows[r].is_cfg) begin
                drain_pipeline();
                write_entry(rows[r].stage, rows[r].idx, rows[r].key, rows[r].val);
            end else begin
                queue_header(rows[r].hdr, rows[r].exp, $sformatf("row %0d", r));
            end
        end
        drain_pipeline();

        // back-pressure from the output
        hold_credit = 1'b1;
        out_mark    = out_seen;
        crd_mark    = in_crd_seen;
        for (int i = 0; i < N_HOLD; i++) begin
            rnd = $random(seed);
            h   = {$random(seed), $random(seed)};
            if (rnd[0]) begin
                h[0] = 8'h00;
            end
            queue_header(h, predict_header(h), $sformatf("hold %0d", i));
        end
        repeat (40) run_cycle();
        assert (out_seen - out_mark == OUT_CREDITS)
            else abort_run("stage 1 did not stop once its output credits ran out");
        // buffer 1 slots plus what stage 1 passed on
        assert (in_crd_seen - crd_mark <= BUF_DEPTH + OUT_CREDITS)
            else abort_run("more input credits came back than the pipeline can hold");
        hold_credit = 1'b0;
        drain_pipeline();

        for (int i = 0; i < N_RAND; i++) begin
            rnd = $random(seed);
            h   = {$random(seed), $random(seed)};
            if (rnd[0]) begin
                h[0] = 8'h00;
            end else if (rnd[1]) begin
                h[0] = 8'h88;
            end
            queue_header(h, predict_header(h), $sformatf("random %0d", i));
        end
        drain_pipeline();

        // an empty pipeline holds every input credit again
        if (in_credits == BUF_DEPTH) begin
            $display("Testbench passed");
            $finish;
        end else begin
            abort_run($sformatf("only %0d of %0d input credits came back after the drain",
                                in_credits, BUF_DEPTH));
        end
    end

endmodule

// File: flist.f
common/switch_pkg.sv
common/tbl_cfg_if.sv
hdl/hdr_buffer.sv
match_action_stage/match_table.sv
match_action_stage/match_action_stage.sv
hdl/switch_pipeline.sv
testbench/hdr_buffer_checker.sv
testbench/tb_switch_pipeline.sv

// File: run_sim.sh
#!/bin/sh
# build and run the switch pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_switch_pipeline -f flist.f -o tb_sim \
    && { ./obj_dir/tb_sim > sim.log 2>&1 || true; } \
    && cat sim.log \
    && grep -q "Testbench passed" sim.log \
    && echo "simulation PASS" \
    || { echo "Testbench failed"; exit 1; }
